// ==== all.f ====
+incdir+logic
logic/graph_bus_pkg.sv
logic/rr_arbiter.sv
logic/bus_arbiter.sv
logic/bus_config_regs.sv
logic/graph_bus_top.sv
dv/graph_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the graph bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module graph_bus_tb -o graph_bus_sim

sim_output=$(./obj_dir/graph_bus_sim 2>&1) || true
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== dv/graph_bus_tb.sv ====
// graph bus testbench with random PE traffic, a reference arbiter and APB register checks
`timescale 1ns/1ns
`default_nettype none

`include "graph_bus_macros.svh"

module graph_bus_tb;

    localparam int num_pe      = `GRAPH_BUS_NUM_PE;
    localparam int cnt_w       = `GRAPH_BUS_CNT_W;
    localparam int drain_limit = 200;
    localparam int apb_limit   = 8;
    localparam logic [num_pe-1:0] all_pes = '1;
    localparam logic [num_pe-1:0] even_pes = 4'b0101;
    localparam logic [num_pe-1:0] odd_pes = 4'b1010;

    logic                          clk;
    logic                          reset;
    graph_bus_pkg::bus_req_t       pe_req [num_pe];
    logic [num_pe-1:0]             pe_grant;
    graph_bus_pkg::mem_cntl_info_t neighbor_info;
    graph_bus_pkg::mem_cntl_info_t feature_info;
    graph_bus_pkg::apb_req_t       apb_req;
    graph_bus_pkg::apb_rsp_t       apb_rsp;

    // reference model state
    logic [31:0]       seed;
    logic [num_pe-1:0] exp_mask;
    int                ref_ptr;
    logic [num_pe-1:0] xfer_mask;
    logic [num_pe-1:0] xfer_seen;
    logic [cnt_w-1:0]  nb_count;
    logic [cnt_w-1:0]  ft_count;
    graph_bus_pkg::mem_cntl_info_t nb_expect [$];
    graph_bus_pkg::mem_cntl_info_t ft_expect [$];

    // scratch for the compare process
    logic [num_pe-1:0]             mon_reqs;
    logic [num_pe-1:0]             mon_grant;
    graph_bus_pkg::mem_cntl_info_t mon_nb;
    graph_bus_pkg::mem_cntl_info_t mon_ft;
    graph_bus_pkg::mem_cntl_info_t mon_word;

    graph_bus_top graph_bus_top_inst (
        .clk          (clk),
        .reset        (reset),
        .pe_req       (pe_req),
        .pe_grant     (pe_grant),
        .neighbor_info(neighbor_info),
        .feature_info (feature_info),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    function logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // first live requester after the last winner, in circular order
    function automatic logic [num_pe-1:0] expected_grant(input logic [num_pe-1:0] reqs,
                                                         input logic [num_pe-1:0] mask,
                                                         input int last);
        logic [num_pe-1:0] live;
        logic [num_pe-1:0] onehot;
        int                cand;
        live   = reqs & mask;
        onehot = '0;
        for (int step = 1; step <= num_pe; step++) begin
            cand = (last + step) % num_pe;
            if (live[cand]) begin
                onehot[cand] = 1'b1;
                return onehot;
            end
        end
        return onehot;
    endfunction

    task automatic check_grant(input logic [num_pe-1:0] got, input logic [num_pe-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED pe_grant got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_info(input graph_bus_pkg::mem_cntl_info_t got,
                              input graph_bus_pkg::mem_cntl_info_t exp,
                              input string name);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_apb(input logic [31:0] got, input logic [31:0] exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // predict each grant and compare its channel word one cycle later
    always @(negedge clk) begin
        #2;
        if (reset) begin
            mon_nb = '0;
            mon_ft = '0;
            if (nb_expect.size() > 0) begin
                mon_nb = nb_expect.pop_front();
            end
            if (ft_expect.size() > 0) begin
                mon_ft = ft_expect.pop_front();
            end
            check_info(neighbor_info, mon_nb, "neighbor_info");
            check_info(feature_info, mon_ft, "feature_info");

            for (int i = 0; i < num_pe; i++) begin
                mon_reqs[i] = pe_req[i].req;
            end
            mon_grant = expected_grant(mon_reqs, exp_mask, ref_ptr);
            check_grant(pe_grant, mon_grant);

            mon_nb = '0;
            mon_ft = '0;
            for (int i = 0; i < num_pe; i++) begin
                if (mon_grant[i]) begin
                    ref_ptr          = i;
                    mon_word.valid   = 1'b1;
                    mon_word.node_id = pe_req[i].node_id;
                    mon_word.pe_tag  = pe_req[i].pe_tag;
                    if (pe_req[i].req_type == graph_bus_pkg::REQ_FEATURE) begin
                        mon_ft   = mon_word;
                        ft_count = ft_count + cnt_w'(1);
                    end else begin
                        mon_nb   = mon_word;
                        nb_count = nb_count + cnt_w'(1);
                    end
                end
            end
            nb_expect.push_back(mon_nb);
            ft_expect.push_back(mon_ft);
            // PEs react to the grant they actually see
            xfer_mask = pe_grant;
            xfer_seen = xfer_seen | pe_grant;
        end
    end

    // APB setup and access phases with the write landing at the access edge
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata,
                              output graph_bus_pkg::apb_rsp_t rsp);
        int waited;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        waited = 0;
        while (!apb_rsp.pready) begin
            @(negedge clk);
            #2;
            waited++;
            if (waited > apb_limit) begin
                abort_run("APB access never saw pready");
            end
        end
        rsp = apb_rsp;
        @(posedge clk);
        if (write) begin
            if (addr == graph_bus_pkg::REG_PE_ENABLE) begin
                exp_mask = wdata[num_pe-1:0];
            end else if (addr == graph_bus_pkg::REG_NEIGHBOR_CNT) begin
                nb_count = '0;
            end else if (addr == graph_bus_pkg::REG_FEATURE_CNT) begin
                ft_count = '0;
            end
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] wdata);
        graph_bus_pkg::apb_rsp_t rsp;
        apb_access(1'b1, addr, wdata, rsp);
        check_apb(32'(rsp.pslverr), 32'h0, "pslverr");
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp);
        graph_bus_pkg::apb_rsp_t rsp;
        apb_access(1'b0, addr, 32'h0, rsp);
        check_apb(32'(rsp.pready), 32'h1, "pready");
        check_apb(32'(rsp.pslverr), 32'h0, "pslverr");
        check_apb(rsp.prdata, exp, "prdata");
    endtask

    // a PE only picks a new request once its last one transferred
    task automatic run_traffic(input int cycles, input logic [num_pe-1:0] allowed,
                               input logic [num_pe-1:0] held);
        logic [31:0] rnd;
        repeat (cycles) begin
            @(negedge clk);
            for (int i = 0; i < num_pe; i++) begin
                if (!pe_req[i].req || xfer_mask[i]) begin
                    rnd = lcg_next();
                    pe_req[i].req      = held[i] | (allowed[i] & rnd[20]);
                    pe_req[i].pe_tag   = rnd[9:8];
                    pe_req[i].req_type = graph_bus_pkg::req_type_e'(rnd[16]);
                    pe_req[i].node_id  = rnd[31:22];
                end
            end
        end
    endtask

    task automatic drain_requests(input logic [num_pe-1:0] keep);
        int                waited;
        logic [num_pe-1:0] busy;
        waited = 0;
        busy   = '1;
        while (busy != '0) begin
            @(negedge clk);
            busy = '0;
            for (int i = 0; i < num_pe; i++) begin
                if (xfer_mask[i] && !keep[i]) begin
                    pe_req[i].req = 1'b0;
                end
                busy[i] = pe_req[i].req & ~keep[i];
            end
            waited++;
            if (waited > drain_limit) begin
                abort_run("pending PE requests were not granted in time");
            end
        end
        // wait out the last channel word and its counter update
        repeat (2) @(negedge clk);
    endtask

    task automatic rotation_check();
        logic [num_pe-1:0] want;
        for (int k = 0; k <= num_pe; k++) begin
            run_traffic(1, '0, all_pes);
            #2;
            want = '0;
            want[k % num_pe] = 1'b1;
            check_grant(pe_grant, want);
        end
    endtask

    initial begin
        graph_bus_pkg::apb_rsp_t rsp;
        logic [cnt_w-1:0]        ft_before;
        clk       = 1'b0;
        reset     = 1'b0;
        seed      = 32'd83722;
        exp_mask  = all_pes;
        ref_ptr   = num_pe - 1;
        xfer_mask = '0;
        xfer_seen = '0;
        nb_count  = '0;
        ft_count  = '0;
        apb_req   = '0;
        for (int i = 0; i < num_pe; i++) begin
            pe_req[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // reset values
        @(negedge clk);
        #2;
        check_info(neighbor_info, '0, "neighbor_info");
        check_info(feature_info, '0, "feature_info");
        expect_reg(graph_bus_pkg::REG_PE_ENABLE, 32'(all_pes));
        expect_reg(graph_bus_pkg::REG_NEIGHBOR_CNT, 32'h0);
        expect_reg(graph_bus_pkg::REG_FEATURE_CNT, 32'h0);

        // with all PEs busy the priority walks 0 1 2 3 0
        rotation_check();
        drain_requests('0);

        // random traffic, checked cycle by cycle
        run_traffic(400, all_pes, '0);
        drain_requests('0);

        // PE 1 and PE 3 masked while holding requests
        write_reg(graph_bus_pkg::REG_PE_ENABLE, 32'(even_pes));
        xfer_seen = '0;
        run_traffic(60, even_pes, odd_pes);
        drain_requests(odd_pes);
        if ((xfer_seen & odd_pes) != '0) begin
            abort_run("a masked PE was granted");
        end
        xfer_seen = '0;
        write_reg(graph_bus_pkg::REG_PE_ENABLE, 32'(all_pes));
        drain_requests('0);
        if ((xfer_seen & odd_pes) != odd_pes) begin
            abort_run("re-enabled PE 1 and PE 3 were not both granted");
        end

        // transfer counters against the reference counts
        if (nb_count == '0 || ft_count == '0) begin
            abort_run("traffic produced no transfers of one request type");
        end
        expect_reg(graph_bus_pkg::REG_NEIGHBOR_CNT, 32'(nb_count));
        expect_reg(graph_bus_pkg::REG_FEATURE_CNT, 32'(ft_count));

        // unmapped address leaves every register alone
        apb_access(1'b0, 4'hc, 32'h0, rsp);
        check_apb(32'(rsp.pslverr), 32'h1, "pslverr");
        check_apb(32'(rsp.pready), 32'h1, "pready");
        apb_access(1'b1, 4'hc, 32'h0, rsp);
        check_apb(32'(rsp.pslverr), 32'h1, "pslverr");
        expect_reg(graph_bus_pkg::REG_PE_ENABLE, 32'(all_pes));
        expect_reg(graph_bus_pkg::REG_NEIGHBOR_CNT, 32'(nb_count));
        expect_reg(graph_bus_pkg::REG_FEATURE_CNT, 32'(ft_count));

        // clearing the neighbor count keeps the feature count
        ft_before = ft_count;
        write_reg(graph_bus_pkg::REG_NEIGHBOR_CNT, 32'hdead_beef);
        expect_reg(graph_bus_pkg::REG_NEIGHBOR_CNT, 32'h0);
        expect_reg(graph_bus_pkg::REG_FEATURE_CNT, 32'(ft_before));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/graph_bus_top.sv ====
// graph bus top joining the request arbiter and its APB register block
`timescale 1ns/1ns
`default_nettype none

`include "graph_bus_macros.svh"

module graph_bus_top (
    input  wire                           clk,
    input  wire                           reset,
    input  wire graph_bus_pkg::bus_req_t  pe_req [`GRAPH_BUS_NUM_PE],
    output logic [`GRAPH_BUS_NUM_PE-1:0]  pe_grant,
    output graph_bus_pkg::mem_cntl_info_t neighbor_info,
    output graph_bus_pkg::mem_cntl_info_t feature_info,
    input  wire graph_bus_pkg::apb_req_t  apb_req,
    output graph_bus_pkg::apb_rsp_t       apb_rsp
);

    // mask from the register block into the arbiter
    logic [`GRAPH_BUS_NUM_PE-1:0] pe_enable;

    bus_arbiter bus_arbiter_inst (
        .clk          (clk),
        .reset        (reset),
        .pe_req       (pe_req),
        .pe_enable    (pe_enable),
        .pe_grant     (pe_grant),
        .neighbor_info(neighbor_info),
        .feature_info (feature_info)
    );

    // counts transfers off the same channel words the arbiter drives out
    bus_config_regs bus_config_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .neighbor_info(neighbor_info),
        .feature_info (feature_info),
        .pe_enable    (pe_enable)
    );

endmodule

`default_nettype wire

// ==== logic/bus_config_regs.sv ====
// APB register block with the PE enable mask and per-channel transfer counters
`timescale 1ns/1ns
`default_nettype none

`include "graph_bus_macros.svh"

module bus_config_regs (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire graph_bus_pkg::apb_req_t        apb_req,
    output graph_bus_pkg::apb_rsp_t             apb_rsp,
    input  wire graph_bus_pkg::mem_cntl_info_t  neighbor_info,
    input  wire graph_bus_pkg::mem_cntl_info_t  feature_info,
    output logic [`GRAPH_BUS_NUM_PE-1:0]        pe_enable
);

    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic [31:0] rd_data;

    // entry 0 counts neighbor transfers, entry 1 feature transfers
    logic [`GRAPH_BUS_CNT_W-1:0] xfer_cnt [2];
    logic [1:0]                  cnt_inc;
    logic [1:0]                  cnt_clr;

    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    // read mux and address decode
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            graph_bus_pkg::REG_PE_ENABLE:    rd_data = 32'(pe_enable);
            graph_bus_pkg::REG_NEIGHBOR_CNT: rd_data = 32'(xfer_cnt[0]);
            graph_bus_pkg::REG_FEATURE_CNT:  rd_data = 32'(xfer_cnt[1]);
            default:                         addr_hit = 1'b0;
        endcase
    end

    // zero wait states
    always_comb begin
        apb_rsp.prdata  = access ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~addr_hit;
    end

    // only the low PE-count bits of the write data matter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pe_enable <= '1;
        end else if (wr_en && apb_req.paddr == graph_bus_pkg::REG_PE_ENABLE) begin
            pe_enable <= apb_req.pwdata[`GRAPH_BUS_NUM_PE-1:0];
        end
    end

    assign cnt_inc = {feature_info.valid, neighbor_info.valid};
    assign cnt_clr[0] = wr_en && apb_req.paddr == graph_bus_pkg::REG_NEIGHBOR_CNT;
    assign cnt_clr[1] = wr_en && apb_req.paddr == graph_bus_pkg::REG_FEATURE_CNT;

    // clear wins over a same-cycle increment, counters wrap
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            xfer_cnt[0] <= '0;
            xfer_cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cnt_clr[i]) begin
                    xfer_cnt[i] <= '0;
                end else if (cnt_inc[i]) begin
                    xfer_cnt[i] <= xfer_cnt[i] + 1'b1;
                end
            end
        end
    end

    a_penable_with_psel: assert property (
        @(posedge clk) disable iff (!reset) apb_req.penable |-> apb_req.psel
    ) else $error("bus_config_regs: penable without psel");

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
// bus arbiter that grants one enabled PE per cycle and routes it to a channel
`timescale 1ns/1ns
`default_nettype none

`include "graph_bus_macros.svh"

module bus_arbiter (
    input  wire                          clk,
    input  wire                          reset,
    input  wire graph_bus_pkg::bus_req_t pe_req [`GRAPH_BUS_NUM_PE],
    input  wire [`GRAPH_BUS_NUM_PE-1:0]  pe_enable,
    output logic [`GRAPH_BUS_NUM_PE-1:0] pe_grant,
    output graph_bus_pkg::mem_cntl_info_t neighbor_info,
    output graph_bus_pkg::mem_cntl_info_t feature_info
);

    logic [`GRAPH_BUS_NUM_PE-1:0] masked_req;
    graph_bus_pkg::bus_req_t granted_req;
    graph_bus_pkg::mem_cntl_info_t nx_neighbor_info;
    graph_bus_pkg::mem_cntl_info_t nx_feature_info;

    // a disabled PE never reaches the arbiter
    always_comb begin
        for (int i = 0; i < `GRAPH_BUS_NUM_PE; i++) begin
            masked_req[i] = pe_req[i].req & pe_enable[i];
        end
    end

    rr_arbiter #(
        .num_reqs(`GRAPH_BUS_NUM_PE)
    ) rr_arbiter_inst (
        .clk   (clk),
        .reset (reset),
        .reqs  (masked_req),
        .grants(pe_grant)
    );

    // grant is one-hot so at most one request is picked
    always_comb begin
        granted_req = '0;
        for (int i = 0; i < `GRAPH_BUS_NUM_PE; i++) begin
            if (pe_grant[i]) begin
                granted_req = pe_req[i];
            end
        end
    end

    // steer the granted request by its type
    always_comb begin
        nx_neighbor_info = '0;
        nx_feature_info  = '0;
        if (granted_req.req) begin
            case (granted_req.req_type)
                graph_bus_pkg::REQ_NEIGHBOR: begin
                    nx_neighbor_info.valid   = 1'b1;
                    nx_neighbor_info.node_id = granted_req.node_id;
                    nx_neighbor_info.pe_tag  = granted_req.pe_tag;
                end
                graph_bus_pkg::REQ_FEATURE: begin
                    nx_feature_info.valid   = 1'b1;
                    nx_feature_info.node_id = granted_req.node_id;
                    nx_feature_info.pe_tag  = granted_req.pe_tag;
                end
                default: begin
                    nx_neighbor_info = '0;
                    nx_feature_info  = '0;
                end
            endcase
        end
    end

    // channel words go out one cycle after the transfer
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            neighbor_info <= '0;
            feature_info  <= '0;
        end else begin
            neighbor_info <= nx_neighbor_info;
            feature_info  <= nx_feature_info;
        end
    end

    a_one_channel: assert property (
        @(posedge clk) disable iff (!reset) !(neighbor_info.valid && feature_info.valid)
    ) else $error("bus_arbiter: both channels valid");

endmodule

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
// round-robin arbiter with a rotating priority pointer and a one-hot grant
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  wire                clk,
    input  wire                reset,
    input  wire [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    // index of the last granted requester, which has the lowest priority
    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] grant_idx;

    // search starts one past the pointer and wraps around
    always_comb begin
        int   idx;
        logic found;
        grants    = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int k = 1; k <= num_reqs; k++) begin
            idx = (int'(ptr) + k) % num_reqs;
            if (!found && reqs[idx]) begin
                found       = 1'b1;
                grants[idx] = 1'b1;
                grant_idx   = ptr_w'(idx);
            end
        end
    end

    // out of reset the last requester is lowest, so requester 0 wins first
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ptr <= ptr_w'(num_reqs - 1);
        end else if (|grants) begin
            ptr <= grant_idx;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!reset) $onehot0(grants)
    ) else $error("rr_arbiter: more than one grant");

    a_grant_has_req: assert property (
        @(posedge clk) disable iff (!reset) (grants & ~reqs) == '0
    ) else $error("rr_arbiter: grant without request");

endmodule

`default_nettype wire

// ==== logic/graph_bus_pkg.sv ====
// graph bus types for PE requests, memory controller channels and the APB port
`default_nettype none

`include "graph_bus_macros.svh"

package graph_bus_pkg;

    // field widths derived from the sizing macros
    localparam int PE_TAG_W  = $clog2(`GRAPH_BUS_NUM_PE);
    localparam int NODE_ID_W = $clog2(`GRAPH_BUS_MAX_NODE_ID);

    // what a PE asks for about its node
    typedef enum logic {
        REQ_NEIGHBOR = 1'b0,
        REQ_FEATURE  = 1'b1
    } req_type_e;

    // one PE request, held until granted
    typedef struct packed {
        logic                 req;
        logic [PE_TAG_W-1:0]  pe_tag;
        req_type_e            req_type;
        logic [NODE_ID_W-1:0] node_id;
    } bus_req_t;

    // word on a memory controller channel
    typedef struct packed {
        logic                 valid;
        logic [NODE_ID_W-1:0] node_id;
        logic [PE_TAG_W-1:0]  pe_tag;
    } mem_cntl_info_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map of the config block
    typedef enum logic [3:0] {
        REG_PE_ENABLE    = 4'h0,
        REG_NEIGHBOR_CNT = 4'h4,
        REG_FEATURE_CNT  = 4'h8
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== logic/graph_bus_macros.svh ====
// graph bus sizing macros for the PE count, node id range and counter width
`ifndef GRAPH_BUS_MACROS_SVH
`define GRAPH_BUS_MACROS_SVH

// number of edge PEs sharing the request bus
`define GRAPH_BUS_NUM_PE 4

// node ids span this range, so an id is its clog2 wide
`define GRAPH_BUS_MAX_NODE_ID 1024

// width of each per-channel transfer counter
`define GRAPH_BUS_CNT_W 16

`endif
